//--- run_sim.sh
#!/bin/sh
# build and run the banked wishbone RAM testbench with Verilator
# exit status is 0 only when the log holds the pass message

cd "$(dirname "$0")" || exit 1

TOP=tb_wb_bank_ram
BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module "$TOP" -Mdir "$BUILD_DIR" -f verilog.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST OK$" "$LOG"; then
    echo "simulation passed"
    exit 0
else
    echo "pass message not found in $LOG"
    exit 1
fi

//--- source/bank_port_if.sv
// one access from the bus controller to the RAM banks
// ctrl launches, each bank answers on its own rdata entry, ret picks the word
`timescale 1ns/10ps
`include "wbram_settings.svh"

interface bank_port_if import wbram_pkg::*; ();

    logic [`WBRAM_BSEL_W-1:0]  bank_id; // target bank
    logic [`WBRAM_BANK_AW-1:0] addr;    // word address inside the bank
    logic [`WBRAM_DATA_W-1:0]  wdata;
    logic [`WBRAM_BE_W-1:0]    be;
    bus_op_e                   op;
    logic                      strobe;  // one cycle per launched access

    // registered read word of every bank
    logic [`WBRAM_DATA_W-1:0] rdata [`WBRAM_NUM_BANKS];

    modport ctrl (
        output bank_id, addr, wdata, be, op, strobe
    );

    modport bank (
        input  bank_id, addr, wdata, be, op, strobe,
        output rdata
    );

    modport ret (
        input bank_id, strobe, rdata
    );

endinterface

//--- source/bank_read_return.sv
// read-return stage of the banked RAM
// remembers which bank took the last strobe and puts that bank's
// registered word on the bus in the response cycle of a good read
`timescale 1ns/10ps
`include "wbram_settings.svh"

module bank_read_return (
    input  logic                     clk,
    input  logic                     rst_n_i,
    input  logic                     rd_valid_i,
    bank_port_if.ret                 bus,
    output logic [`WBRAM_DATA_W-1:0] dat_o
);

    logic [`WBRAM_BSEL_W-1:0] bank_q;
    logic [`WBRAM_DATA_W-1:0] sel_word;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            bank_q <= '0;
        end else if (bus.strobe) begin
            bank_q <= bus.bank_id;
        end
    end

    // mux over the populated banks only
    always_comb begin
        sel_word = '0;
        for (int i = 0; i < `WBRAM_NUM_BANKS; i++) begin
            if (bank_q == `WBRAM_BSEL_W'(i)) begin
                sel_word = bus.rdata[i];
            end
        end
    end

    // zero on writes and errors
    assign dat_o = rd_valid_i ? sel_word : '0;

endmodule

//--- source/ram_bank.sv
// one byte-enabled synchronous single-port RAM bank
// answers only strobes addressed to BANK_INDEX, read word valid next cycle
// and held until the bank's next access
`timescale 1ns/10ps
`include "wbram_settings.svh"

module ram_bank import wbram_pkg::*; #(
    parameter int BANK_INDEX = 0
) (
    input logic       clk,
    bank_port_if.bank bus
);

    localparam int DEPTH = 2 ** `WBRAM_BANK_AW;

    logic [`WBRAM_DATA_W-1:0] mem [DEPTH];
    logic [`WBRAM_DATA_W-1:0] rdata_q;
    logic                     hit;

    // own index selected on a launched access
    assign hit = bus.strobe & (bus.bank_id == `WBRAM_BSEL_W'(BANK_INDEX));

    // write and read capture share the strobe edge
    // the nonblocking read sees the old word
    always_ff @(posedge clk) begin
        if (hit) begin
            if (bus.op == OP_WRITE) begin
                for (int b = 0; b < `WBRAM_BE_W; b++) begin
                    if (bus.be[b]) begin
                        mem[bus.addr][8*b +: 8] <= bus.wdata[8*b +: 8];
                    end
                end
            end
            rdata_q <= mem[bus.addr];
        end
    end

    assign bus.rdata[BANK_INDEX] = rdata_q; // this bank's slot only

endmodule

//--- source/wb_bank_ctrl.sv
// wishbone classic slave front end of the banked RAM
// splits the word address into bank number and bank address, launches
// one access per request and answers with a single-cycle ack or err
`timescale 1ns/10ps
`include "wbram_settings.svh"

module wb_bank_ctrl import wbram_pkg::*; (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic [`WBRAM_BUS_AW-1:0]  adr_i,
    input  logic [`WBRAM_DATA_W-1:0]  dat_i,
    input  logic [`WBRAM_BE_W-1:0]    sel_i,
    input  logic                      we_i,
    input  logic                      stb_i,
    input  logic                      cyc_i,
    output logic                      ack_o,
    output logic                      err_o,
    output logic                      rd_valid_o,
    bank_port_if.ctrl                 bus
);

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic [`WBRAM_BSEL_W-1:0]  bank_num;
    logic [`WBRAM_BANK_AW-1:0] bank_addr;
    logic                      bank_ok;
    logic                      req;

    logic ack_q;
    logic err_q;
    logic rd_q;

    // upper bits pick the bank, the rest address a word in it
    assign bank_num  = adr_i[`WBRAM_BUS_AW-1 -: `WBRAM_BSEL_W];
    assign bank_addr = adr_i[`WBRAM_BANK_AW-1:0];

    // slots at or above the bank count are unpopulated
    assign bank_ok = (32'(bank_num) < 32'(`WBRAM_NUM_BANKS));

    // a new request is only taken in IDLE, stb_i is ignored during RESP
    assign req = cyc_i & stb_i & (state_q == IDLE);

    assign bus.bank_id = bank_num;
    assign bus.addr    = bank_addr;
    assign bus.wdata   = dat_i;
    assign bus.be      = sel_i;
    assign bus.op      = we_i ? OP_WRITE : OP_READ;
    assign bus.strobe  = req & bank_ok; // nothing reaches the banks on an error

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (req) begin
                    state_d = RESP;
                end
            end
            RESP: state_d = IDLE; // response lasts exactly one cycle
            default: state_d = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
            rd_q    <= 1'b0;
        end else begin
            state_q <= state_d;
            ack_q   <= req & bank_ok;
            err_q   <= req & ~bank_ok;
            rd_q    <= req & bank_ok & ~we_i; // good read, return stage drives dat_o
        end
    end

    assign ack_o      = ack_q;
    assign err_o      = err_q;
    assign rd_valid_o = rd_q;

endmodule

//--- source/wb_bank_ram_top.sv
// top level of the banked wishbone RAM
// plain wishbone classic slave ports, one controller, a row of
// identical banks and the read-return stage on a shared bank port
`timescale 1ns/10ps
`include "wbram_settings.svh"

module wb_bank_ram_top (
    input  logic                      clk,
    input  logic                      rst_n_i,
    input  logic [`WBRAM_BUS_AW-1:0]  adr_i,
    input  logic [`WBRAM_DATA_W-1:0]  dat_i,
    input  logic [`WBRAM_BE_W-1:0]    sel_i,
    input  logic                      we_i,
    input  logic                      stb_i,
    input  logic                      cyc_i,
    output logic [`WBRAM_DATA_W-1:0]  dat_o,
    output logic                      ack_o,
    output logic                      err_o
);

    logic rd_valid; // good read finishing this cycle

    bank_port_if bank_bus ();

    wb_bank_ctrl wb_bank_ctrl_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .adr_i      (adr_i),
        .dat_i      (dat_i),
        .sel_i      (sel_i),
        .we_i       (we_i),
        .stb_i      (stb_i),
        .cyc_i      (cyc_i),
        .ack_o      (ack_o),
        .err_o      (err_o),
        .rd_valid_o (rd_valid),
        .bus        (bank_bus)
    );

    // one bank per populated slot, each matching its own index
    for (genvar g = 0; g < `WBRAM_NUM_BANKS; g++) begin : g_bank
        ram_bank #(
            .BANK_INDEX (g)
        ) ram_bank_inst (
            .clk (clk),
            .bus (bank_bus)
        );
    end

    bank_read_return bank_read_return_inst (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .rd_valid_i (rd_valid),
        .bus        (bank_bus),
        .dat_o      (dat_o)
    );

endmodule

//--- source/wbram_pkg.sv
// types shared by the bus controller, the banks and the bank port
// import by wildcard in the module header where an enum is needed
`include "wbram_settings.svh"

package wbram_pkg;

    // controller FSM, one response cycle after every accepted request
    typedef enum logic [0:0] {
        IDLE = 1'b0, // waiting for stb/cyc
        RESP = 1'b1  // ack or err on the bus
    } ctrl_state_e;

    // kind of the access launched to the banks
    typedef enum logic [0:0] {
        OP_READ  = 1'b0,
        OP_WRITE = 1'b1
    } bus_op_e;

endpackage

//--- source/wbram_settings.svh
// sizes shared by the banked wishbone RAM
// include in every RTL file that needs a width or the bank count
`ifndef WBRAM_SETTINGS_SVH
`define WBRAM_SETTINGS_SVH

// bus and bank word width
`define WBRAM_DATA_W 32

// word address bits inside one bank, 256 words
`define WBRAM_BANK_AW 8

`define WBRAM_NUM_BANKS 3 // populated banks, need not be a power of two
`define WBRAM_BSEL_W 2    // bank-number field, slot 3 left empty

// full word address seen on the bus
`define WBRAM_BUS_AW (`WBRAM_BSEL_W + `WBRAM_BANK_AW)

`define WBRAM_BE_W (`WBRAM_DATA_W / 8) // one enable per byte lane

`endif

//--- testbench/tb_wb_bank_ram.sv
// testbench for the banked wishbone RAM
// random wishbone master with a byte-masked reference memory, checks every
// response for value and timing, stops at the first mismatch
`timescale 1ns/10ps
`include "wbram_settings.svh"

module tb_wb_bank_ram;

    localparam int AW  = `WBRAM_BUS_AW;
    localparam int DW  = `WBRAM_DATA_W;
    localparam int BEW = `WBRAM_BE_W;
    localparam int BSW = `WBRAM_BSEL_W;
    localparam int NB  = `WBRAM_NUM_BANKS;

    localparam int NUM_WORDS    = NB * (2 ** `WBRAM_BANK_AW); // populated words only
    localparam int N_RANDOM     = 2000;
    localparam int N_LANES      = 60;  // write plus read each
    localparam int N_UNMAPPED   = 40;  // bad access plus alias read each
    localparam int RESET_CYCLES = 5;
    localparam int IDLE_CYCLES  = 20;
    localparam int CYC_PER_XFER = 3;   // request, response, stb low

    // fill and readback, random mix, directed, then reset and slack
    localparam int TIMEOUT_CYCLES =
        (2 * NUM_WORDS + N_RANDOM + 2 * N_LANES + 2 * N_UNMAPPED) * CYC_PER_XFER + 1000;

    logic           clk;
    logic           rst_n_i;
    logic [AW-1:0]  adr_i;
    logic [DW-1:0]  dat_i;
    logic [BEW-1:0] sel_i;
    logic           we_i;
    logic           stb_i;
    logic           cyc_i;
    logic [DW-1:0]  dat_o;
    logic           ack_o;
    logic           err_o;

    logic [DW-1:0]  model_mem [NUM_WORDS];
    logic [BEW-1:0] model_wr  [NUM_WORDS]; // byte lanes written so far
    int             cycle_count = 0;

    wb_bank_ram_top wb_bank_ram_top_inst (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .adr_i   (adr_i),
        .dat_i   (dat_i),
        .sel_i   (sel_i),
        .we_i    (we_i),
        .stb_i   (stb_i),
        .cyc_i   (cyc_i),
        .dat_o   (dat_o),
        .ack_o   (ack_o),
        .err_o   (err_o)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run();
        $display("TEST FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // hung bus guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run hung, no response from the DUT within %0d cycles", TIMEOUT_CYCLES);
            abort_run();
        end
    end

    task automatic check_val(input string test, input string what,
                             input logic [DW-1:0] exp, input logic [DW-1:0] act);
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %h, actual %h", test, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_flag(input string test, input string what,
                              input logic exp, input logic act);
        assert (act === exp) else begin
            $display("FAIL %s %s: expected %b, actual %b", test, what, exp, act);
            abort_run();
        end
    endtask

    // byte enables widened to a bit mask
    function automatic logic [DW-1:0] lane_bits(input logic [BEW-1:0] lanes);
        logic [DW-1:0] bits;
        bits = '0;
        for (int b = 0; b < BEW; b++) begin
            if (lanes[b]) begin
                bits[8*b +: 8] = 8'hff;
            end
        end
        return bits;
    endfunction

    function automatic logic [AW-1:0] bank_word_addr(input int bank, input logic [7:0] word);
        return {BSW'(bank), word};
    endfunction

    // one classic cycle, checked against the model
    task automatic access(input string test, input logic we, input logic [AW-1:0] adr,
                          input logic [DW-1:0] dat, input logic [BEW-1:0] sel);
        int            lat;
        int            idx;
        logic          mapped;
        logic          got_ack;
        logic          got_err;
        logic [DW-1:0] got_dat;
        logic [DW-1:0] keep;
        mapped = (int'(adr[AW-1 -: BSW]) < NB); // unpopulated slots must give err
        idx    = int'(adr);
        @(posedge clk);
        adr_i <= adr;
        dat_i <= dat;
        sel_i <= sel;
        we_i  <= we;
        stb_i <= 1'b1;
        cyc_i <= 1'b1;
        @(negedge clk);
        assert (!ack_o && !err_o) else begin
            $display("%s: response appeared before the request was sampled", test);
            abort_run();
        end
        lat = 0;
        do begin
            @(posedge clk);
            @(negedge clk);
            lat++;
        end while (!(ack_o || err_o));
        got_ack = ack_o;
        got_err = err_o;
        got_dat = dat_o;
        assert (lat == 1) else begin
            $display("%s: response came %0d cycles after the request edge, not 1", test, lat);
            abort_run();
        end
        check_flag(test, "ack_o", mapped, got_ack);
        check_flag(test, "err_o", !mapped, got_err);
        if (we) begin
            check_val(test, "dat_o", '0, got_dat); // nothing returned on writes
            if (mapped) begin
                keep = lane_bits(sel);
                model_mem[idx] = (model_mem[idx] & ~keep) | (dat & keep);
                model_wr[idx]  = model_wr[idx] | sel;
            end
        end else if (mapped) begin
            keep = lane_bits(model_wr[idx]); // unwritten bytes are undefined
            check_val(test, "dat_o", model_mem[idx] & keep, got_dat & keep);
        end else begin
            check_val(test, "dat_o", '0, got_dat);
        end
        @(posedge clk);
        stb_i <= 1'b0;
        cyc_i <= 1'b0;
        we_i  <= 1'b0;
        @(negedge clk);
        assert (!ack_o && !err_o) else begin
            $display("%s: response stayed high for more than one cycle", test);
            abort_run();
        end
    endtask

    initial begin
        logic [7:0] word;
        int         bank;
        logic       we;
        void'($urandom(32'h2ef1_6447));
        rst_n_i = 1'b0;
        adr_i   = '0;
        dat_i   = '0;
        sel_i   = '0;
        we_i    = 1'b0;
        stb_i   = 1'b0;
        cyc_i   = 1'b0;
        for (int i = 0; i < NUM_WORDS; i++) begin
            model_wr[i] = '0;
        end

        // reset_idle
        for (int c = 0; c < RESET_CYCLES; c++) begin
            @(posedge clk);
            if (c == RESET_CYCLES - 1) begin
                rst_n_i <= 1'b1;
            end
            @(negedge clk);
            check_flag("reset_idle", "ack_o", 1'b0, ack_o);
            check_flag("reset_idle", "err_o", 1'b0, err_o);
        end
        repeat (IDLE_CYCLES) begin
            @(negedge clk);
            check_flag("reset_idle", "ack_o", 1'b0, ack_o);
            check_flag("reset_idle", "err_o", 1'b0, err_o);
        end

        // fill_readback, every populated word written in full
        for (int i = 0; i < NUM_WORDS; i++) begin
            access("fill_readback", 1'b1, AW'(i), DW'($urandom), '1);
        end
        for (int i = 0; i < NUM_WORDS; i++) begin
            access("fill_readback", 1'b0, AW'(i), '0, '1);
        end

        // byte_lanes
        repeat (N_LANES) begin
            bank = int'($urandom % NB);
            word = 8'($urandom);
            access("byte_lanes", 1'b1, bank_word_addr(bank, word), DW'($urandom),
                   BEW'($urandom));
            access("byte_lanes", 1'b0, bank_word_addr(bank, word), '0, '1);
        end

        // unmapped_err, then the bank 0 word with the same low bits
        repeat (N_UNMAPPED) begin
            word = 8'($urandom);
            we   = 1'($urandom);
            access("unmapped_err", we, bank_word_addr(NB, word), DW'($urandom), '1);
            access("unmapped_err", 1'b0, bank_word_addr(0, word), '0, '1);
        end

        // random_mix over every slot, covers bank isolation
        repeat (N_RANDOM) begin
            we = 1'($urandom);
            access("random_mix", we, AW'($urandom), DW'($urandom), BEW'($urandom));
        end

        $display("TEST OK");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/wbram_pkg.sv
source/bank_port_if.sv
source/wb_bank_ctrl.sv
source/ram_bank.sv
source/bank_read_return.sv
source/wb_bank_ram_top.sv
testbench/tb_wb_bank_ram.sv
